// File: adpcmb_chk.sv
// bus and pipeline protocol checks, bound into the channel top by the testbench
`timescale 1ns/10ps

module adpcmb_chk import adpcmb_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              wb_cyc,
    input logic              wb_stb,
    input logic              wb_ack,
    input logic              sample_valid,
    input logic              rom_rd,
    input logic [ADDR_W-1:0] rom_addr,
    input logic [ABLK_W-1:0] astart,
    input logic [ABLK_W-1:0] aend
);

    // ack only inside an active access
    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack high without cyc and stb");

    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid longer than one cycle");

    // one nibble in flight, so reads never back to back
    rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rom_rd |=> !rom_rd)
        else $error("rom_rd high in two consecutive cycles");

    rd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        rom_rd |-> (rom_addr[ADDR_W-1:8] >= astart && rom_addr[ADDR_W-1:8] <= aend))
        else $error("rom_addr outside the start to end blocks");

endmodule

// File: adpcmb_cnt.sv
// sample clock-enable, delta step counter and nibble address walk for the channel
`timescale 1ns/10ps

module adpcmb_cnt import adpcmb_pkg::*; #(
    parameter int CEN_DIV = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              on,
    input  logic              rep,
    input  logic              clr,
    input  logic [ABLK_W-1:0] astart,
    input  logic [ABLK_W-1:0] aend,
    input  logic [15:0]       delta,
    output logic              adv,          // one clk per nibble
    output logic [ADDR_W-1:0] addr,
    output logic              nibble_sel,   // 0 = high nibble
    output logic              restart,
    output logic              end_hit
);

    localparam int DIV_W = $clog2(CEN_DIV);

    logic [DIV_W-1:0] div;
    logic             cen;
    logic [15:0]      cnt;
    logic [16:0]      sum;       // carry in bit 16
    logic             last_on;
    logic             done;      // stopped at end, no repeat

    assign cen     = (div == DIV_W'(CEN_DIV - 1));
    assign sum     = {1'b0, cnt} + {1'b0, delta};
    assign restart = clr || (on && !last_on);   // rising edge of on or clr

    // free running divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            div <= '0;
        else if (cen)
            div <= '0;
        else
            div <= div + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_on    <= 1'b0;
            cnt        <= '0;
            adv        <= 1'b0;
            end_hit    <= 1'b0;
            done       <= 1'b0;
            addr       <= '0;
            nibble_sel <= 1'b0;
        end else begin
            last_on <= on;
            adv     <= 1'b0;
            end_hit <= 1'b0;
            if (restart || !on) begin
                // park at start, also while off
                cnt        <= '0;
                done       <= 1'b0;
                addr       <= {astart, 8'h00};
                nibble_sel <= 1'b0;
            end else begin
                if (cen) begin
                    cnt <= sum[15:0];
                    adv <= sum[16] && !done;   // carry out advances
                end
                if (adv) begin
                    if (addr[ADDR_W-1:8] < aend) begin
                        {addr, nibble_sel} <= {addr, nibble_sel} + (ADDR_W + 1)'(1);
                    end else if (rep) begin
                        addr       <= {astart, 8'h00};   // loop back
                        nibble_sel <= 1'b0;
                    end else begin
                        end_hit <= 1'b1;
                        done    <= 1'b1;   // hold until restart
                    end
                end
            end
        end
    end

endmodule

// File: adpcmb_decode.sv
// adaptive ADPCM-B decoder with step adaptation, saturation and output level scaling
`timescale 1ns/10ps

module adpcmb_decode import adpcmb_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               restart,
    input  logic [3:0]         nib,
    input  logic               nib_valid,
    input  logic [7:0]         level,
    output logic signed [15:0] sample_out,
    output logic               sample_valid
);

    logic signed [15:0]  acc;
    logic [STEP_W-1:0]   step;
    logic [2:0]          mag;
    logic [3:0]          mul_odd;      // 2*mag+1
    logic [STEP_W+3:0]   diff_full;
    logic [STEP_W:0]     diff;         // step*(2m+1)/8
    logic signed [17:0]  acc_ext;
    logic signed [17:0]  diff_ext;
    logic signed [17:0]  acc_sum;      // headroom before saturation
    logic signed [15:0]  acc_next;
    logic [STEP_W+7:0]   step_prod;
    logic [STEP_W+1:0]   step_scaled;  // step*mult/64
    logic [STEP_W-1:0]   step_next;
    logic signed [23:0]  scaled;

    assign mag       = nib[2:0];
    assign mul_odd   = {mag, 1'b1};
    assign diff_full = step * mul_odd;
    assign diff      = diff_full[STEP_W+3:3];   // truncating divide

    assign acc_ext  = acc;                      // sign extend
    assign diff_ext = {2'b00, diff};
    assign acc_sum  = nib[3] ? acc_ext - diff_ext : acc_ext + diff_ext;

    // clip to 16-bit signed
    always_comb begin
        if (acc_sum > 18'sd32767)
            acc_next = 16'sh7fff;
        else if (acc_sum < -18'sd32768)
            acc_next = 16'sh8000;
        else
            acc_next = acc_sum[15:0];
    end

    assign step_prod   = step * step_mult[mag];
    assign step_scaled = step_prod[STEP_W+7:6];

    // step clamp
    always_comb begin
        if (step_scaled < STEP_MIN)
            step_next = STEP_W'(STEP_MIN);
        else if (step_scaled > STEP_MAX)
            step_next = STEP_W'(STEP_MAX);
        else
            step_next = step_scaled[STEP_W-1:0];
    end

    assign scaled = acc_next * $signed({1'b0, level});   // level is unsigned

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            step         <= STEP_W'(STEP_MIN);
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (restart) begin
                acc  <= '0;      // fresh start
                step <= STEP_W'(STEP_MIN);
            end else if (nib_valid) begin
                acc          <= acc_next;
                step         <= step_next;
                sample_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (nib_valid && !restart)
            sample_out <= scaled[23:8];   // >>8 of acc*level
    end

endmodule

// File: adpcmb_fetch.sv
// reads sample memory on each advance and hands the selected nibble to the decoder
`timescale 1ns/10ps

module adpcmb_fetch import adpcmb_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              adv,
    input  logic [ADDR_W-1:0] addr,
    input  logic              nibble_sel,
    input  logic [7:0]        rom_data,    // valid one cycle after rom_rd
    output logic              rom_rd,
    output logic [ADDR_W-1:0] rom_addr,
    output logic [3:0]        nib,
    output logic              nib_valid
);

    typedef enum logic [1:0] {
        idle,
        read,      // rom_rd high
        select     // rom_data valid
    } fetch_st_e;

    fetch_st_e         state;
    logic [ADDR_W-1:0] addr_q;
    logic              sel_q;

    assign rom_rd   = (state == read);
    assign rom_addr = addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            nib_valid <= 1'b0;
        end else begin
            nib_valid <= 1'b0;
            case (state)
                idle:    if (adv) state <= read;
                read:    state <= select;
                select: begin
                    nib_valid <= 1'b1;
                    state     <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // address latch and nibble pick
    always_ff @(posedge clk) begin
        if (state == idle && adv) begin
            addr_q <= addr;
            sel_q  <= nibble_sel;
        end
        if (state == select)
            nib <= sel_q ? rom_data[3:0] : rom_data[7:4];   // high first
    end

endmodule

// File: adpcmb_pkg.sv
// register map, control bit positions, widths and step table shared by the ADPCM-B channel
package adpcmb_pkg;

    localparam int ADDR_W = 24;      // byte address into sample memory
    localparam int ABLK_W = 16;      // start and end, in 256-byte blocks
    localparam int STEP_W = 15;      // decoder step register, holds STEP_MAX

    // adaptive step limits
    localparam int STEP_MIN = 127;
    localparam int STEP_MAX = 24576;

    // wishbone register addresses
    typedef enum logic [3:0] {
        reg_ctrl     = 4'd0,
        reg_start_lo = 4'd1,
        reg_start_hi = 4'd2,
        reg_end_lo   = 4'd3,
        reg_end_hi   = 4'd4,
        reg_delta_lo = 4'd5,
        reg_delta_hi = 4'd6,
        reg_level    = 4'd7,
        reg_status   = 4'd8
    } reg_addr_e;

    // bit positions inside ctrl
    typedef enum int unsigned {
        ctrl_on     = 0,
        ctrl_repeat = 1,
        ctrl_clr    = 2     // write-only pulse
    } ctrl_bit_e;

    // step multipliers in 1/64 units, indexed by nibble magnitude
    localparam logic [7:0] step_mult [8] = '{
        8'd57, 8'd57, 8'd57, 8'd57,
        8'd77, 8'd102, 8'd128, 8'd153
    };

endpackage

// File: adpcmb_regs.sv
// wishbone classic register file of the channel, feeds counter and decoder with settings
`timescale 1ns/10ps

module adpcmb_regs import adpcmb_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [3:0]        wb_adr,
    input  logic [7:0]        wb_dat_i,
    input  logic              end_hit,   // from counter, sets eos
    output logic [7:0]        wb_dat_o,
    output logic              wb_ack,
    output logic              on,
    output logic              rep,
    output logic              clr,       // one cycle
    output logic [ABLK_W-1:0] astart,
    output logic [ABLK_W-1:0] aend,
    output logic [15:0]       delta,
    output logic [7:0]        level,
    output logic              eos
);

    reg_addr_e  adr;
    logic       req;       // fresh access seen this cycle
    logic       acked;     // ack given, wait for stb low
    logic       wr;
    logic [7:0] rd_data;

    assign adr = reg_addr_e'(wb_adr);
    assign req = wb_cyc && wb_stb && !wb_ack && !acked;
    assign wr  = req && wb_we;

    // read mux
    always_comb begin
        rd_data = 8'h00;
        case (adr)
            reg_ctrl: begin
                rd_data[ctrl_on]     = on;
                rd_data[ctrl_repeat] = rep;   // clr reads back 0
            end
            reg_start_lo: rd_data = astart[7:0];
            reg_start_hi: rd_data = astart[15:8];
            reg_end_lo:   rd_data = aend[7:0];
            reg_end_hi:   rd_data = aend[15:8];
            reg_delta_lo: rd_data = delta[7:0];
            reg_delta_hi: rd_data = delta[15:8];
            reg_level:    rd_data = level;
            reg_status:   rd_data[0] = eos;
            default:      rd_data = 8'h00;     // unmapped
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            acked    <= 1'b0;
            wb_dat_o <= 8'h00;
            on       <= 1'b0;
            rep      <= 1'b0;
            clr      <= 1'b0;
            astart   <= '0;
            aend     <= '0;
            delta    <= '0;
            level    <= '0;
            eos      <= 1'b0;
        end else begin
            wb_ack <= req;     // single cycle ack
            clr    <= 1'b0;
            if (!wb_cyc || !wb_stb)
                acked <= 1'b0;
            else if (wb_ack)
                acked <= 1'b1;
            if (req)
                wb_dat_o <= rd_data;
            if (wr) begin
                case (adr)
                    reg_ctrl: begin
                        on  <= wb_dat_i[ctrl_on];
                        rep <= wb_dat_i[ctrl_repeat];
                        clr <= wb_dat_i[ctrl_clr];
                    end
                    reg_start_lo: astart[7:0]  <= wb_dat_i;
                    reg_start_hi: astart[15:8] <= wb_dat_i;
                    reg_end_lo:   aend[7:0]    <= wb_dat_i;
                    reg_end_hi:   aend[15:8]   <= wb_dat_i;
                    reg_delta_lo: delta[7:0]   <= wb_dat_i;
                    reg_delta_hi: delta[15:8]  <= wb_dat_i;
                    reg_level:    level        <= wb_dat_i;
                    reg_status:   if (wb_dat_i[0]) eos <= 1'b0;   // write 1 to clear
                    default: ;
                endcase
            end
            if (end_hit)
                eos <= 1'b1;   // set beats clear
        end
    end

endmodule

// File: adpcmb_top.sv
// ADPCM-B channel top, register file plus counter, fetch and decode stages
`timescale 1ns/10ps

module adpcmb_top import adpcmb_pkg::*; #(
    parameter int CEN_DIV = 4    // clk cycles per sample enable, at least 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [3:0]         wb_adr,
    input  logic [7:0]         wb_dat_i,
    output logic [7:0]         wb_dat_o,
    output logic               wb_ack,
    output logic               rom_rd,
    output logic [ADDR_W-1:0]  rom_addr,
    input  logic [7:0]         rom_data,
    output logic signed [15:0] sample_out,
    output logic               sample_valid,
    output logic               eos
);

    // register file outputs
    logic              on;
    logic              rep;
    logic              clr;
    logic [ABLK_W-1:0] astart;
    logic [ABLK_W-1:0] aend;
    logic [15:0]       delta;
    logic [7:0]        level;
    // pipeline
    logic              end_hit;
    logic              adv;
    logic [ADDR_W-1:0] addr;
    logic              nibble_sel;
    logic              restart;
    logic [3:0]        nib;
    logic              nib_valid;

    adpcmb_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .end_hit  (end_hit),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .on       (on),
        .rep      (rep),
        .clr      (clr),
        .astart   (astart),
        .aend     (aend),
        .delta    (delta),
        .level    (level),
        .eos      (eos)
    );

    adpcmb_cnt #(
        .CEN_DIV (CEN_DIV)
    ) i_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .on         (on),
        .rep        (rep),
        .clr        (clr),
        .astart     (astart),
        .aend       (aend),
        .delta      (delta),
        .adv        (adv),
        .addr       (addr),
        .nibble_sel (nibble_sel),
        .restart    (restart),
        .end_hit    (end_hit)
    );

    adpcmb_fetch i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .adv        (adv),
        .addr       (addr),
        .nibble_sel (nibble_sel),
        .rom_data   (rom_data),
        .rom_rd     (rom_rd),
        .rom_addr   (rom_addr),
        .nib        (nib),
        .nib_valid  (nib_valid)
    );

    adpcmb_decode i_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .restart      (restart),
        .nib          (nib),
        .nib_valid    (nib_valid),
        .level        (level),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

endmodule

// File: project.f
adpcmb_pkg.sv
adpcmb_regs.sv
adpcmb_cnt.sv
adpcmb_fetch.sv
adpcmb_decode.sv
adpcmb_top.sv
adpcmb_chk.sv
tb_adpcmb.sv

// File: run.sh
#!/bin/sh
# builds the ADPCM-B testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_adpcmb -f project.f
./obj_dir/Vtb_adpcmb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run ended early, see sim.log"
    exit 1
fi
echo "run passed"

// File: tb_adpcmb.sv
// testbench for the ADPCM-B channel, plays a test table against a memory model and reference decoder
`timescale 1ns/10ps

module tb_adpcmb import adpcmb_pkg::*; ();

    localparam int NT     = 5;       // table rows
    localparam int MEM_SZ = 4096;    // 16 blocks of sample data

    logic               clk;
    logic               rst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [3:0]         wb_adr;
    logic [7:0]         wb_dat_i;
    logic [7:0]         wb_dat_o;
    logic               wb_ack;
    logic               rom_rd;
    logic [ADDR_W-1:0]  rom_addr;
    logic [7:0]         rom_data;
    logic signed [15:0] sample_out;
    logic               sample_valid;
    logic               eos;

    // test table, one column per field
    string       t_name   [NT] = '{"decode", "level", "end", "repeat", "clear"};
    logic [15:0] t_start  [NT] = '{16'd1, 16'd1, 16'd3, 16'd5, 16'd7};
    logic [15:0] t_end    [NT] = '{16'd2, 16'd2, 16'd4, 16'd6, 16'd8};
    logic [15:0] t_delta  [NT] = '{16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'h4000};
    bit          t_rep    [NT] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    logic [7:0]  t_level  [NT] = '{8'd255, 8'd64, 8'd255, 8'd255, 8'd255};
    int          t_count  [NT] = '{40, 40, 600, 560, 30};   // cap on samples
    int          t_clr    [NT] = '{0, 0, 0, 0, 12};         // clr after this many

    // register readback values
    reg_addr_e   r_addr [8] = '{reg_ctrl, reg_start_lo, reg_start_hi, reg_end_lo,
                                reg_end_hi, reg_delta_lo, reg_delta_hi, reg_level};
    logic [7:0]  r_val  [8] = '{8'h02, 8'ha5, 8'h3c, 8'h0f, 8'hf0, 8'h34, 8'h12, 8'h81};

    logic [7:0]        mem [MEM_SZ];
    logic              mem_rd;
    logic [ADDR_W-1:0] mem_a;
    string             name;
    int                errs;
    int                npass;
    int                nfail;
    int                start_hits;    // reads of the start byte
    // reference model state
    int                m_acc;
    int                m_step;
    logic [ADDR_W-1:0] m_addr;
    bit                m_sel;
    bit                m_done;
    logic [15:0]       cur_start;
    logic [15:0]       cur_end;
    bit                cur_rep;

    adpcmb_top #(.CEN_DIV(4)) i_adpcmb_top (.*);

    bind adpcmb_top adpcmb_chk i_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_ack       (wb_ack),
        .sample_valid (sample_valid),
        .rom_rd       (rom_rd),
        .rom_addr     (rom_addr),
        .astart       (astart),
        .aend         (aend)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // sample memory, data one cycle after rom_rd
    always @(posedge clk) begin
        mem_rd = rom_rd;
        mem_a  = rom_addr;
        #1;
        if (mem_rd) begin
            rom_data = mem[mem_a[11:0]];
            if (mem_a == {cur_start, 8'h00})
                start_hits++;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] ctrl_word(input bit on, input bit rep, input bit clr);
        logic [7:0] w;
        w              = 8'h00;
        w[ctrl_on]     = on;
        w[ctrl_repeat] = rep;
        w[ctrl_clr]    = clr;
        return w;
    endfunction

    task automatic mismatch(input int exp, input int act);
        $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        errs++;
    endtask

    // one classic cycle, ack sampled on the edge after it rises
    task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [7:0] din,
                           output logic [7:0] dout);
        int n;
        bit seen;
        seen     = 1'b0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = din;
        for (n = 0; n < 20 && !seen; n++) begin
            @(posedge clk);
            #1;
            seen = wb_ack;
        end
        dout = wb_dat_o;   // read data comes with ack
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);    // slave rearms once it sees stb low
        #1;
        if (!seen) begin
            $display("no wishbone ack for register %0d in test %s", adr, name);
            errs++;
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [7:0] din);
        logic [7:0] unused;
        wb_xfer(1'b1, adr, din, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [7:0] dout);
        wb_xfer(1'b0, adr, 8'h00, dout);
    endtask

    task automatic wait_sample(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 200 && !ok; n++) begin
            @(posedge clk);
            #1;
            ok = sample_valid;
        end
    endtask

    task automatic model_restart(input int t);
        cur_start = t_start[t];
        cur_end   = t_end[t];
        cur_rep   = t_rep[t];
        m_acc     = 0;
        m_step    = STEP_MIN;
        m_addr    = {cur_start, 8'h00};
        m_sel     = 1'b0;
        m_done    = 1'b0;
    endtask

    // next nibble by the address rule, high nibble first
    task automatic model_nibble(output logic [3:0] n);
        logic [7:0] b;
        b = mem[m_addr[11:0]];
        n = m_sel ? b[3:0] : b[7:4];
        if (m_addr[ADDR_W-1:8] < cur_end) begin
            if (m_sel)
                m_addr = m_addr + 1;
            m_sel = !m_sel;
        end else if (cur_rep) begin
            m_addr = {cur_start, 8'h00};   // wrap, no decoder reset
            m_sel  = 1'b0;
        end else begin
            m_done = 1'b1;
        end
    endtask

    task automatic model_decode(input logic [3:0] n, input int lvl, output int smp);
        int mag;
        int d;
        mag = n[2:0];
        d   = (m_step * (2 * mag + 1)) / 8;
        m_acc = n[3] ? m_acc - d : m_acc + d;
        if (m_acc > 32767)
            m_acc = 32767;
        else if (m_acc < -32768)
            m_acc = -32768;
        m_step = (m_step * int'(step_mult[mag])) / 64;
        if (m_step < STEP_MIN)
            m_step = STEP_MIN;
        else if (m_step > STEP_MAX)
            m_step = STEP_MAX;
        smp = (m_acc * lvl) >>> 8;
    endtask

    task automatic finish_test(input int cnt);
        if (errs == 0) begin
            npass++;
            $display("PASS %s, %0d samples", name, cnt);
        end else begin
            nfail++;
            $display("FAIL %s, %0d samples, %0d errors", name, cnt, errs);
        end
    endtask

    initial begin
        int         t;
        int         i;
        int         got;
        int         smp;
        int         quiet;
        bit         ok;
        bit         tmo;
        logic [3:0] n;
        logic [7:0] rd;
        logic [31:0] x;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 4'h0;
        wb_dat_i   = 8'h00;
        rom_data   = 8'h00;
        npass      = 0;
        nfail      = 0;
        start_hits = 0;
        cur_start  = 16'h0000;
        x = 32'd74;    // seed
        for (i = 0; i < MEM_SZ; i++) begin
            x      = xorshift(x);
            mem[i] = x[7:0];
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // register readback, status clear after reset
        name = "regs";
        errs = 0;
        wb_read(reg_status, rd);
        if (rd !== 8'h00)
            mismatch(0, rd);
        for (i = 0; i < 8; i++) begin
            wb_write(r_addr[i], r_val[i]);
            wb_read(r_addr[i], rd);
            if (rd !== r_val[i])
                mismatch(r_val[i], rd);
        end
        finish_test(0);

        for (t = 0; t < NT; t++) begin
            name = t_name[t];
            errs = 0;
            wb_write(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b0));
            repeat (12) @(posedge clk);    // drain the last nibble in flight
            #1;
            wb_write(reg_start_lo, t_start[t][7:0]);
            wb_write(reg_start_hi, t_start[t][15:8]);
            wb_write(reg_end_lo, t_end[t][7:0]);
            wb_write(reg_end_hi, t_end[t][15:8]);
            wb_write(reg_delta_lo, t_delta[t][7:0]);
            wb_write(reg_delta_hi, t_delta[t][15:8]);
            wb_write(reg_level, t_level[t]);
            model_restart(t);
            start_hits = 0;
            wb_write(reg_ctrl, ctrl_word(1'b1, t_rep[t], 1'b0));   // rising on restarts
            got = 0;
            tmo = 1'b0;
            while (got < t_count[t] && !m_done && !tmo) begin
                if (t_clr[t] != 0 && got == t_clr[t]) begin
                    wb_write(reg_ctrl, ctrl_word(1'b1, t_rep[t], 1'b1));
                    model_restart(t);
                end
                model_nibble(n);
                model_decode(n, t_level[t], smp);
                wait_sample(ok);
                if (!ok) begin
                    $display("timeout in test %s, no sample after %0d samples", name, got);
                    errs++;
                    tmo = 1'b1;
                end else if (sample_out !== 16'(smp)) begin
                    mismatch(smp, sample_out);
                end
                got++;
            end
            if (m_done) begin
                wb_read(reg_status, rd);
                if (rd !== 8'h01)
                    mismatch(1, rd);
                if (eos !== 1'b1)
                    mismatch(1, eos);
                quiet = 0;
                for (i = 0; i < 64; i++) begin
                    @(posedge clk);
                    #1;
                    if (sample_valid)
                        quiet++;
                end
                if (quiet != 0) begin
                    $display("test %s: %0d samples came after end of sample", name, quiet);
                    errs++;
                end
                wb_write(reg_status, 8'h01);    // write 1 clears eos
                wb_read(reg_status, rd);
                if (rd !== 8'h00)
                    mismatch(0, rd);
            end
            if (t_rep[t] && start_hits < 3) begin
                $display("ERR %s: expected at least 3 start reads, actual %0d", name, start_hits);
                errs++;
            end
            finish_test(got);
        end

        $display("tests passed: %0d, failed: %0d", npass, nfail);
        if (nfail == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
